/* hdl/idu_settings.svh */
// decode stage widths

`ifndef IDU_SETTINGS_SVH
`define IDU_SETTINGS_SVH

// register and operand width
`define IDU_XLEN 64

// base instruction length, no compressed forms
`define IDU_ILEN 32

// general purpose registers, x0 included
`define IDU_NREGS 32

// register index width, log2 of IDU_NREGS
`define IDU_REG_AW 5

`endif

/* hdl/rv_isa_pkg.sv */
// RISC-V instruction set types

`include "idu_settings.svh"

`default_nettype none

package rv_isa_pkg;

  typedef logic [`IDU_XLEN-1:0]   xlen_t;
  typedef logic [`IDU_ILEN-1:0]   inst_t;
  typedef logic [`IDU_REG_AW-1:0] reg_idx_t;
  typedef logic [2:0]             funct3_t;
  typedef logic [6:0]             funct7_t;

  // major opcodes, bits 6..0
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,  // addiw and word shifts
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,  // addw, subw, word shifts
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  // immediate format, same codes as the execute side expects
  typedef enum logic [2:0] {
    FMT_I = 3'd0,
    FMT_U = 3'd1,
    FMT_S = 3'd2,
    FMT_B = 3'd3,
    FMT_J = 3'd4,
    FMT_R = 3'd7   // no immediate
  } inst_fmt_e;

  // R-type view of a word; rs1, rs2, rd sit at the same place in every format
  typedef struct packed {
    funct7_t  funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    funct3_t  funct3;
    reg_idx_t rd;
    opcode_e  opcode;
  } inst_fields_t;

endpackage

`default_nettype wire

/* hdl/idu_ctrl_pkg.sv */
// decode control word types

`default_nettype none

package idu_ctrl_pkg;

  // ALU operation codes
  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,   // also signed branch compare
    ALU_SLTU     = 5'd3,   // also unsigned branch compare
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_COPY_IMM = 5'd15,  // lui
    ALU_INVALID  = 5'd31
  } alu_op_e;

  // load/store width and sign, S = signed, U = zero extended
  typedef enum logic [2:0] {
    MEM_SB   = 3'd0,
    MEM_UB   = 3'd1,
    MEM_SH   = 3'd2,
    MEM_UH   = 3'd3,
    MEM_SW   = 3'd4,
    MEM_UW   = 3'd5,
    MEM_SD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_JAL  = 3'd1,
    BR_JALR = 3'd2,
    BR_EQ   = 3'd4,
    BR_NE   = 3'd5,
    BR_LT   = 3'd6,   // bltu too, alu_op tells them apart
    BR_GE   = 3'd7
  } branch_e;

  typedef enum logic [1:0] {
    SRC_RS2  = 2'd0,
    SRC_IMM  = 2'd1,
    SRC_FOUR = 2'd2   // link address pc + 4
  } alu_b_src_e;

  typedef struct packed {
    branch_e    branch;
    logic       alu_a_is_pc;
    alu_b_src_e alu_b_src;
    alu_op_e    alu_op;
    logic       word_cut;     // result cut to 32 bits and sign extended
    logic       reg_wr;
    logic       mem_to_reg;
    logic       mem_wr;
    logic       mem_re;
    mem_op_e    mem_op;
    logic       ebreak;
    logic       invalid;
  } idu_ctrl_t;

endpackage

`default_nettype wire

/* hdl/imm_gen.sv */
// immediate generator

`include "idu_settings.svh"

`default_nettype none

module imm_gen (
  input  wire rv_isa_pkg::inst_t     i_inst,
  input  wire rv_isa_pkg::inst_fmt_e i_fmt,
  output rv_isa_pkg::xlen_t          o_imm
);

  logic              sign;
  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_u;
  rv_isa_pkg::xlen_t imm_s;
  rv_isa_pkg::xlen_t imm_b;
  rv_isa_pkg::xlen_t imm_j;

  assign sign = i_inst[31];  // every format keeps its sign here

  assign imm_i = {{(`IDU_XLEN-12){sign}}, i_inst[31:20]};
  assign imm_u = {{(`IDU_XLEN-32){sign}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(`IDU_XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`IDU_XLEN-12){sign}}, i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{(`IDU_XLEN-20){sign}}, i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      rv_isa_pkg::FMT_I: o_imm = imm_i;
      rv_isa_pkg::FMT_U: o_imm = imm_u;
      rv_isa_pkg::FMT_S: o_imm = imm_s;
      rv_isa_pkg::FMT_B: o_imm = imm_b;
      rv_isa_pkg::FMT_J: o_imm = imm_j;
      default:           o_imm = '0;  // R format
    endcase
  end

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
// RV64I instruction decoder

`default_nettype none

module inst_decoder (
  input  wire rv_isa_pkg::inst_t   i_inst,
  output rv_isa_pkg::inst_fmt_e    o_fmt,
  output idu_ctrl_pkg::idu_ctrl_t  o_ctrl
);

  rv_isa_pkg::inst_fields_t f;
  logic                     known;      // a supported encoding
  logic                     is_ebreak;
  logic                     imm_alt;    // srai/sraiw, imm bit 30 only counts on funct3 101
  logic                     f7_zero;
  logic                     f7_alt;
  logic                     sh_zero;    // 64-bit shamt takes funct7 bit 0
  logic                     sh_alt;

  // shared by register and immediate arithmetic
  function automatic idu_ctrl_pkg::alu_op_e arith_op(input rv_isa_pkg::funct3_t funct3,
                                                     input logic alt);
    idu_ctrl_pkg::alu_op_e op;
    case (funct3)
      3'b000:  op = alt ? idu_ctrl_pkg::ALU_SUB : idu_ctrl_pkg::ALU_ADD;
      3'b001:  op = idu_ctrl_pkg::ALU_SLL;
      3'b010:  op = idu_ctrl_pkg::ALU_SLT;
      3'b011:  op = idu_ctrl_pkg::ALU_SLTU;
      3'b100:  op = idu_ctrl_pkg::ALU_XOR;
      3'b101:  op = alt ? idu_ctrl_pkg::ALU_SRA : idu_ctrl_pkg::ALU_SRL;
      3'b110:  op = idu_ctrl_pkg::ALU_OR;
      default: op = idu_ctrl_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // loads and stores share the funct3 width coding
  function automatic idu_ctrl_pkg::mem_op_e mem_width(input rv_isa_pkg::funct3_t funct3);
    idu_ctrl_pkg::mem_op_e op;
    case (funct3)
      3'b000:  op = idu_ctrl_pkg::MEM_SB;
      3'b001:  op = idu_ctrl_pkg::MEM_SH;
      3'b010:  op = idu_ctrl_pkg::MEM_SW;
      3'b011:  op = idu_ctrl_pkg::MEM_SD;
      3'b100:  op = idu_ctrl_pkg::MEM_UB;
      3'b101:  op = idu_ctrl_pkg::MEM_UH;
      3'b110:  op = idu_ctrl_pkg::MEM_UW;
      default: op = idu_ctrl_pkg::MEM_NONE;
    endcase
    return op;
  endfunction

  assign f         = i_inst;
  assign f7_zero   = f.funct7 == 7'b0000000;
  assign f7_alt    = f.funct7 == 7'b0100000;
  assign sh_zero   = f.funct7[6:1] == 6'b000000;
  assign sh_alt    = f.funct7[6:1] == 6'b010000;
  assign imm_alt   = (f.funct3 == 3'b101) & f.funct7[5];
  assign is_ebreak = (f.opcode == rv_isa_pkg::OPC_SYSTEM) & (f.funct3 == 3'b000) &
                     ({f.funct7, f.rs2} == 12'h001);

  always_comb begin
    known         = 1'b0;
    o_fmt         = rv_isa_pkg::FMT_R;
    o_ctrl        = '0;
    o_ctrl.alu_op = idu_ctrl_pkg::ALU_INVALID;
    o_ctrl.mem_op = idu_ctrl_pkg::MEM_NONE;

    case (f.opcode)
      rv_isa_pkg::OPC_LUI: begin
        known         = 1'b1;
        o_fmt         = rv_isa_pkg::FMT_U;
        o_ctrl.alu_op = idu_ctrl_pkg::ALU_COPY_IMM;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        known         = 1'b1;
        o_fmt         = rv_isa_pkg::FMT_U;
        o_ctrl.alu_op = idu_ctrl_pkg::ALU_ADD;
      end
      rv_isa_pkg::OPC_JAL: begin
        known         = 1'b1;
        o_fmt         = rv_isa_pkg::FMT_J;
        o_ctrl.alu_op = idu_ctrl_pkg::ALU_ADD;
        o_ctrl.branch = idu_ctrl_pkg::BR_JAL;
      end
      rv_isa_pkg::OPC_JALR: begin
        known         = f.funct3 == 3'b000;
        o_fmt         = rv_isa_pkg::FMT_I;
        o_ctrl.alu_op = idu_ctrl_pkg::ALU_ADD;
        o_ctrl.branch = idu_ctrl_pkg::BR_JALR;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        known         = f.funct3[2:1] != 2'b01;
        o_fmt         = rv_isa_pkg::FMT_B;
        o_ctrl.alu_op = f.funct3[1] ? idu_ctrl_pkg::ALU_SLTU : idu_ctrl_pkg::ALU_SLT;
        if (f.funct3[2]) begin
          o_ctrl.branch = f.funct3[0] ? idu_ctrl_pkg::BR_GE : idu_ctrl_pkg::BR_LT;
        end else begin
          o_ctrl.branch = f.funct3[0] ? idu_ctrl_pkg::BR_NE : idu_ctrl_pkg::BR_EQ;
        end
      end
      rv_isa_pkg::OPC_LOAD: begin
        known         = f.funct3 != 3'b111;  // no ldu
        o_fmt         = rv_isa_pkg::FMT_I;
        o_ctrl.alu_op = idu_ctrl_pkg::ALU_ADD;
        o_ctrl.mem_op = mem_width(f.funct3);
      end
      rv_isa_pkg::OPC_STORE: begin
        known         = !f.funct3[2];
        o_fmt         = rv_isa_pkg::FMT_S;
        o_ctrl.alu_op = idu_ctrl_pkg::ALU_ADD;
        o_ctrl.mem_op = mem_width(f.funct3);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        known         = (f.funct3 == 3'b001) ? sh_zero :
                        (f.funct3 == 3'b101) ? (sh_zero | sh_alt) : 1'b1;
        o_fmt         = rv_isa_pkg::FMT_I;
        o_ctrl.alu_op = arith_op(f.funct3, imm_alt);
      end
      rv_isa_pkg::OPC_OP_IMM_32: begin
        known         = (f.funct3 == 3'b000) | ((f.funct3 == 3'b001) & f7_zero) |
                        ((f.funct3 == 3'b101) & (f7_zero | f7_alt));
        o_fmt         = rv_isa_pkg::FMT_I;
        o_ctrl.alu_op = arith_op(f.funct3, imm_alt);
      end
      rv_isa_pkg::OPC_OP: begin
        known         = f7_zero | (f7_alt & (f.funct3 inside {3'b000, 3'b101}));
        o_ctrl.alu_op = arith_op(f.funct3, f.funct7[5]);
      end
      rv_isa_pkg::OPC_OP_32: begin
        known         = ((f.funct3 == 3'b001) & f7_zero) |
                        ((f.funct3 inside {3'b000, 3'b101}) & (f7_zero | f7_alt));
        o_ctrl.alu_op = arith_op(f.funct3, f.funct7[5]);
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        known = is_ebreak;  // alu_op stays INVALID
        o_fmt = rv_isa_pkg::FMT_I;
      end
      default: known = 1'b0;
    endcase

    if (!known) begin
      o_fmt         = rv_isa_pkg::FMT_R;
      o_ctrl.alu_op = idu_ctrl_pkg::ALU_INVALID;
      o_ctrl.branch = idu_ctrl_pkg::BR_NONE;
      o_ctrl.mem_op = idu_ctrl_pkg::MEM_NONE;
    end

    o_ctrl.reg_wr      = known & (o_fmt inside {rv_isa_pkg::FMT_R, rv_isa_pkg::FMT_I,
                                                rv_isa_pkg::FMT_U, rv_isa_pkg::FMT_J});
    o_ctrl.alu_a_is_pc = known & (f.opcode inside {rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR,
                                                   rv_isa_pkg::OPC_AUIPC});
    if (o_ctrl.branch inside {idu_ctrl_pkg::BR_JAL, idu_ctrl_pkg::BR_JALR}) begin
      o_ctrl.alu_b_src = idu_ctrl_pkg::SRC_FOUR;
    end else if (known && (o_fmt inside {rv_isa_pkg::FMT_I, rv_isa_pkg::FMT_U,
                                          rv_isa_pkg::FMT_S})) begin
      o_ctrl.alu_b_src = idu_ctrl_pkg::SRC_IMM;
    end else begin
      o_ctrl.alu_b_src = idu_ctrl_pkg::SRC_RS2;
    end
    o_ctrl.word_cut   = known & (f.opcode inside {rv_isa_pkg::OPC_OP_IMM_32,
                                                  rv_isa_pkg::OPC_OP_32});
    o_ctrl.mem_re     = known & (f.opcode == rv_isa_pkg::OPC_LOAD);
    o_ctrl.mem_to_reg = o_ctrl.mem_re;
    o_ctrl.mem_wr     = known & (f.opcode == rv_isa_pkg::OPC_STORE);
    o_ctrl.ebreak     = is_ebreak;
    o_ctrl.invalid    = (o_ctrl.alu_op == idu_ctrl_pkg::ALU_INVALID) & !is_ebreak &
                        (i_inst != '0);  // all-zero word is a bubble
  end

endmodule

`default_nettype wire

/* hdl/gpr_file.sv */
// general purpose register file

`include "idu_settings.svh"

`default_nettype none

module gpr_file (
  input  wire logic               i_clk,
  input  wire logic               i_rst_n,
  input  wire rv_isa_pkg::inst_t  i_inst,
  input  wire logic               i_wen,
  input  wire rv_isa_pkg::xlen_t  i_wdata,
  output rv_isa_pkg::xlen_t       o_rs1_data,
  output rv_isa_pkg::xlen_t       o_rs2_data
);

  rv_isa_pkg::inst_fields_t f;
  rv_isa_pkg::xlen_t        regs [1:`IDU_NREGS-1];  // x0 has no storage

  assign f = i_inst;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `IDU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (f.rd != '0)) begin
      regs[f.rd] <= i_wdata;
    end
  end

  // async reads, a write shows up the cycle after
  always_comb begin
    o_rs1_data = '0;
    o_rs2_data = '0;
    if (f.rs1 != '0) begin
      o_rs1_data = regs[f.rs1];
    end
    if (f.rs2 != '0) begin
      o_rs2_data = regs[f.rs2];
    end
  end

endmodule

`default_nettype wire

/* hdl/idu_top.sv */
// instruction decode unit

`default_nettype none

module idu_top (
  input  wire logic                i_clk,
  input  wire logic                i_rst_n,
  input  wire rv_isa_pkg::inst_t   i_inst,
  input  wire rv_isa_pkg::xlen_t   i_gpr_wdata,   // write-back value for rd
  output rv_isa_pkg::xlen_t        o_rs1_data,
  output rv_isa_pkg::xlen_t        o_rs2_data,
  output rv_isa_pkg::xlen_t        o_imm,
  output idu_ctrl_pkg::idu_ctrl_t  o_ctrl
);

  rv_isa_pkg::inst_fmt_e    fmt;
  idu_ctrl_pkg::idu_ctrl_t  ctrl;

  assign o_ctrl = ctrl;

  inst_decoder inst_decoder_i (
    .i_inst (i_inst),
    .o_fmt  (fmt),
    .o_ctrl (ctrl)
  );

  imm_gen imm_gen_i (
    .i_inst (i_inst),
    .i_fmt  (fmt),
    .o_imm  (o_imm)
  );

  // rd write qualified by decode, the register file masks x0
  gpr_file gpr_file_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_inst     (i_inst),
    .i_wen      (ctrl.reg_wr),
    .i_wdata    (i_gpr_wdata),
    .o_rs1_data (o_rs1_data),
    .o_rs2_data (o_rs2_data)
  );

endmodule

`default_nettype wire

/* bench/idu_tb_tasks.svh */
// testbench encoders and directed tests

  function automatic rv_isa_pkg::inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input rv_isa_pkg::opcode_e opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input rv_isa_pkg::opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OPC_STORE};
  endfunction

  function automatic rv_isa_pkg::inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_isa_pkg::inst_t u_type(input logic [19:0] imm, input logic [4:0] rd,
      input rv_isa_pkg::opcode_e opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
  endfunction

  function automatic rv_isa_pkg::xlen_t sign_extend(input logic [63:0] v, input int bits);
    logic signed [63:0] t;
    t = v << (64 - bits);
    return t >>> (64 - bits);
  endfunction

  // new word on the rising edge and settled outputs by the falling edge
  task automatic apply_inst(input rv_isa_pkg::inst_t inst, input rv_isa_pkg::xlen_t wdata);
    @(posedge i_clk);
    i_inst      <= inst;
    i_gpr_wdata <= wdata;
    @(negedge i_clk);
  endtask

  task automatic hold_reset(input int n);
    @(posedge i_clk);
    i_rst_n <= 1'b0;
    repeat (n) @(posedge i_clk);
    i_rst_n <= 1'b1;
  endtask

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic ctrl_fields(input rv_isa_pkg::inst_t inst, input idu_ctrl_pkg::alu_op_e op,
      input idu_ctrl_pkg::alu_b_src_e src, input logic word, input logic a_pc, input logic wr);
    apply_inst(inst, '0);
    check_equal("o_ctrl.alu_op", o_ctrl.alu_op, op);
    check_equal("o_ctrl.alu_b_src", o_ctrl.alu_b_src, src);
    check_equal("o_ctrl.word_cut", o_ctrl.word_cut, word);
    check_equal("o_ctrl.alu_a_is_pc", o_ctrl.alu_a_is_pc, a_pc);
    check_equal("o_ctrl.reg_wr", o_ctrl.reg_wr, wr);
    check_equal("o_ctrl.invalid", o_ctrl.invalid, 1'b0);
  endtask

  task automatic registers_read_write();
    rv_isa_pkg::xlen_t data;
    for (int r = 1; r < `IDU_NREGS; r++) begin
      data = {$urandom, $urandom};
      apply_inst(i_type(12'h000, 5'd0, 3'b000, r[4:0], rv_isa_pkg::OPC_OP_IMM), data);
      apply_inst(r_type(7'h00, r[4:0], r[4:0], 3'b000, 5'd0, rv_isa_pkg::OPC_OP), '0);
      check_equal("o_rs1_data", o_rs1_data, data);
      check_equal("o_rs2_data", o_rs2_data, data);
    end
    hold_reset(3);
    for (int r = 0; r < `IDU_NREGS; r++) begin  // add x0, xr, xr
      apply_inst(r_type(7'h00, r[4:0], r[4:0], 3'b000, 5'd0, rv_isa_pkg::OPC_OP), '0);
      check_equal("o_rs1_data", o_rs1_data, '0);
      check_equal("o_rs2_data", o_rs2_data, '0);
    end
    data = {$urandom, $urandom};
    apply_inst(i_type(12'h000, 5'd0, 3'b000, 5'd0, rv_isa_pkg::OPC_OP_IMM), data);
    apply_inst(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, rv_isa_pkg::OPC_OP), '0);
    check_equal("o_rs1_data", o_rs1_data, '0);
    check_equal("o_rs2_data", o_rs2_data, '0);
  endtask

  task automatic immediates_by_format();
    logic [11:0] imm12;
    logic [19:0] imm20;
    for (int s = 0; s < 2; s++) begin  // sign bit clear then set
      imm12 = (s != 0) ? 12'h9a5 : 12'h75a;
      imm20 = (s != 0) ? 20'h8f0c3 : 20'h70f3c;
      apply_inst(i_type(imm12, 5'd1, 3'b000, 5'd2, rv_isa_pkg::OPC_OP_IMM), '0);
      check_equal("o_imm", o_imm, sign_extend(imm12, 12));
      apply_inst(u_type(imm20, 5'd2, rv_isa_pkg::OPC_LUI), '0);
      check_equal("o_imm", o_imm, sign_extend({imm20, 12'h000}, 32));
      apply_inst(s_type(imm12, 5'd3, 5'd1, 3'b011), '0);
      check_equal("o_imm", o_imm, sign_extend(imm12, 12));
      apply_inst(b_type({imm12, 1'b0}, 5'd3, 5'd1, 3'b000), '0);
      check_equal("o_imm", o_imm, sign_extend({imm12, 1'b0}, 13));
      apply_inst(j_type({imm20, 1'b0}, 5'd2), '0);
      check_equal("o_imm", o_imm, sign_extend({imm20, 1'b0}, 21));
    end
  endtask

  task automatic alu_controls();
    logic [2:0] f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    idu_ctrl_pkg::alu_op_e op [10] = '{idu_ctrl_pkg::ALU_ADD, idu_ctrl_pkg::ALU_SUB,
      idu_ctrl_pkg::ALU_SLL, idu_ctrl_pkg::ALU_SLT, idu_ctrl_pkg::ALU_SLTU,
      idu_ctrl_pkg::ALU_XOR, idu_ctrl_pkg::ALU_SRL, idu_ctrl_pkg::ALU_SRA,
      idu_ctrl_pkg::ALU_OR, idu_ctrl_pkg::ALU_AND};
    logic [11:0] imm;
    logic [11:0] imm_w;
    logic        is_shift;
    for (int i = 0; i < 10; i++) begin
      is_shift = f3[i] inside {3'd1, 3'd5};
      imm      = is_shift ? {(alt[i] ? 6'h10 : 6'h00), 6'd33} : 12'h7c1;  // shamt 33
      imm_w    = is_shift ? {(alt[i] ? 7'h20 : 7'h00), 5'd17} : 12'h7c1;
      ctrl_fields(r_type(alt[i] ? 7'h20 : 7'h00, 5'd3, 5'd2, f3[i], 5'd1, rv_isa_pkg::OPC_OP),
                  op[i], idu_ctrl_pkg::SRC_RS2, 1'b0, 1'b0, 1'b1);
      if (!(alt[i] && f3[i] == 3'd0)) begin  // no subi
        ctrl_fields(i_type(imm, 5'd2, f3[i], 5'd1, rv_isa_pkg::OPC_OP_IMM),
                    op[i], idu_ctrl_pkg::SRC_IMM, 1'b0, 1'b0, 1'b1);
      end
      if (f3[i] inside {3'd0, 3'd1, 3'd5}) begin
        ctrl_fields(r_type(alt[i] ? 7'h20 : 7'h00, 5'd3, 5'd2, f3[i], 5'd1,
                           rv_isa_pkg::OPC_OP_32), op[i], idu_ctrl_pkg::SRC_RS2, 1'b1, 1'b0, 1'b1);
        if (!(alt[i] && f3[i] == 3'd0)) begin
          ctrl_fields(i_type(imm_w, 5'd2, f3[i], 5'd1, rv_isa_pkg::OPC_OP_IMM_32),
                      op[i], idu_ctrl_pkg::SRC_IMM, 1'b1, 1'b0, 1'b1);
        end
      end
    end
    ctrl_fields(u_type(20'h12345, 5'd1, rv_isa_pkg::OPC_LUI), idu_ctrl_pkg::ALU_COPY_IMM,
                idu_ctrl_pkg::SRC_IMM, 1'b0, 1'b0, 1'b1);
    ctrl_fields(u_type(20'h12345, 5'd1, rv_isa_pkg::OPC_AUIPC), idu_ctrl_pkg::ALU_ADD,
                idu_ctrl_pkg::SRC_IMM, 1'b0, 1'b1, 1'b1);
  endtask

  task automatic load_store_controls();
    idu_ctrl_pkg::mem_op_e width [7] = '{idu_ctrl_pkg::MEM_SB, idu_ctrl_pkg::MEM_SH,
      idu_ctrl_pkg::MEM_SW, idu_ctrl_pkg::MEM_SD, idu_ctrl_pkg::MEM_UB,
      idu_ctrl_pkg::MEM_UH, idu_ctrl_pkg::MEM_UW};
    for (int i = 0; i < 7; i++) begin
      ctrl_fields(i_type(12'hff8, 5'd2, i[2:0], 5'd1, rv_isa_pkg::OPC_LOAD),
                  idu_ctrl_pkg::ALU_ADD, idu_ctrl_pkg::SRC_IMM, 1'b0, 1'b0, 1'b1);
      check_equal("o_ctrl.mem_op", o_ctrl.mem_op, width[i]);
      check_equal("o_ctrl.mem_re", o_ctrl.mem_re, 1'b1);
      check_equal("o_ctrl.mem_to_reg", o_ctrl.mem_to_reg, 1'b1);
      check_equal("o_ctrl.mem_wr", o_ctrl.mem_wr, 1'b0);
      if (i < 4) begin  // sb..sd
        ctrl_fields(s_type(12'h010, 5'd3, 5'd2, i[2:0]), idu_ctrl_pkg::ALU_ADD,
                    idu_ctrl_pkg::SRC_IMM, 1'b0, 1'b0, 1'b0);
        check_equal("o_ctrl.mem_op", o_ctrl.mem_op, width[i]);
        check_equal("o_ctrl.mem_wr", o_ctrl.mem_wr, 1'b1);
        check_equal("o_ctrl.mem_re", o_ctrl.mem_re, 1'b0);
      end
    end
  endtask

  task automatic branch_jump_controls();
    logic [2:0] f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    idu_ctrl_pkg::branch_e kind [6] = '{idu_ctrl_pkg::BR_EQ, idu_ctrl_pkg::BR_NE,
      idu_ctrl_pkg::BR_LT, idu_ctrl_pkg::BR_GE, idu_ctrl_pkg::BR_LT, idu_ctrl_pkg::BR_GE};
    for (int i = 0; i < 6; i++) begin  // last two are bltu and bgeu
      ctrl_fields(b_type(13'h0040, 5'd3, 5'd2, f3[i]),
                  (i >= 4) ? idu_ctrl_pkg::ALU_SLTU : idu_ctrl_pkg::ALU_SLT,
                  idu_ctrl_pkg::SRC_RS2, 1'b0, 1'b0, 1'b0);
      check_equal("o_ctrl.branch", o_ctrl.branch, kind[i]);
    end
    ctrl_fields(j_type(21'h000800, 5'd1), idu_ctrl_pkg::ALU_ADD, idu_ctrl_pkg::SRC_FOUR,
                1'b0, 1'b1, 1'b1);
    check_equal("o_ctrl.branch", o_ctrl.branch, idu_ctrl_pkg::BR_JAL);
    ctrl_fields(i_type(12'h004, 5'd2, 3'b000, 5'd1, rv_isa_pkg::OPC_JALR),
                idu_ctrl_pkg::ALU_ADD, idu_ctrl_pkg::SRC_FOUR, 1'b0, 1'b1, 1'b1);
    check_equal("o_ctrl.branch", o_ctrl.branch, idu_ctrl_pkg::BR_JALR);
  endtask

  task automatic invalid_flag_cases();
    apply_inst(r_type(7'h01, 5'd3, 5'd2, 3'b000, 5'd1, rv_isa_pkg::OPC_OP), '0);  // mul
    check_equal("o_ctrl.invalid", o_ctrl.invalid, 1'b1);
    apply_inst(i_type(12'h300, 5'd1, 3'b001, 5'd2, rv_isa_pkg::OPC_SYSTEM), '0);  // csrrw
    check_equal("o_ctrl.invalid", o_ctrl.invalid, 1'b1);
    apply_inst(32'h00100073, '0);  // ebreak
    check_equal("o_ctrl.invalid", o_ctrl.invalid, 1'b0);
    check_equal("o_ctrl.ebreak", o_ctrl.ebreak, 1'b1);
    apply_inst('0, '0);
    check_equal("o_ctrl.invalid", o_ctrl.invalid, 1'b0);
    check_equal("o_ctrl.reg_wr", o_ctrl.reg_wr, 1'b0);
    check_equal("o_ctrl.mem_wr", o_ctrl.mem_wr, 1'b0);
    check_equal("o_ctrl.mem_re", o_ctrl.mem_re, 1'b0);
  endtask

/* bench/idu_tb.sv */
// decode stage testbench

`include "idu_settings.svh"

`default_nettype none

module idu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;  // tests need about 170 cycles

  logic                    i_clk = 1'b0;
  logic                    i_rst_n;
  rv_isa_pkg::inst_t       i_inst;
  rv_isa_pkg::xlen_t       i_gpr_wdata;
  rv_isa_pkg::xlen_t       o_rs1_data;
  rv_isa_pkg::xlen_t       o_rs2_data;
  rv_isa_pkg::xlen_t       o_imm;
  idu_ctrl_pkg::idu_ctrl_t o_ctrl;
  int                      cycles = 0;

  idu_top idu_top_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_inst      (i_inst),
    .i_gpr_wdata (i_gpr_wdata),
    .o_rs1_data  (o_rs1_data),
    .o_rs2_data  (o_rs2_data),
    .o_imm       (o_imm),
    .o_ctrl      (o_ctrl)
  );

  `include "idu_tb_tasks.svh"

  always #10 i_clk = ~i_clk;  // 20 ns period

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("tests still running after %0d cycles, giving up", cycles);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    i_rst_n     = 1'b0;
    i_inst      = '0;
    i_gpr_wdata = '0;
    void'($urandom(32'h88cb));
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;

    registers_read_write();
    immediates_by_format();
    alu_controls();
    load_store_controls();
    branch_jump_controls();
    invalid_flag_cases();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
+incdir+bench
hdl/rv_isa_pkg.sv
hdl/idu_ctrl_pkg.sv
hdl/imm_gen.sv
hdl/inst_decoder.sv
hdl/gpr_file.sv
hdl/idu_top.sv
bench/idu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module idu_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vidu_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
